/* pipelinedHart.f */
source/hartPkg.sv
source/hartIfs.sv
source/fetchUnit.sv
source/intExecUnit.sv
source/loadStoreUnit.sv
source/hazardUnit.sv
source/pipelinedHart.sv
tb/clockGen.sv
tb/pipelinedHartChecker.sv
tb/pipelinedHartTb.sv

/* run.sh */
#!/bin/sh
# build and run the pipelined hart testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  --top-module pipelinedHartTb \
  --Mdir obj_dir -o simHart \
  -f pipelinedHart.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/simHart
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

echo "simulation finished"
exit 0

/* source/fetchUnit.sv */
// instruction fetch stage

module fetchUnit #(
  parameter logic [hartPkg::xlen-1:0] resetVector = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [hartPkg::xlen-1:0] instrF,
  input  logic [hartPkg::xlen-1:0] pcTargetE,
  hazardCtrlIf.fetch               hzd,
  output logic [hartPkg::xlen-1:0] pcF,
  output logic [hartPkg::xlen-1:0] pcD,
  output logic [hartPkg::xlen-1:0] instrD
);

  logic [hartPkg::xlen-1:0] pcNextF;

  // redirect from execute wins over sequential fetch
  assign pcNextF = hzd.pcSrcE ? pcTargetE : pcF + 32'd4;

  //////////////////////////////////////////////////////////////////////
  // program counter
  always_ff @(posedge clk) begin
    if (rst) begin
      pcF <= resetVector;
    end else if (!hzd.stallF) begin
      pcF <= pcNextF;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fetch to decode register
  // a flush turns the slot into a bubble
  always_ff @(posedge clk) begin
    if (rst || hzd.flushD) begin
      instrD <= hartPkg::nopInstr;
    end else if (!hzd.stallD) begin
      instrD <= instrF;
      pcD    <= pcF;
    end
  end

endmodule

/* source/hartIfs.sv */
// hart control and memory-stage interfaces

interface hazardCtrlIf;
  // stage stalls and flushes
  logic stallF, stallD, stallE, stallM, stallW;
  logic flushD, flushE, flushW;
  // hazard sources
  logic pcSrcE;
  logic loadUseD;
  logic memBusyM;

  modport hazard (
    output stallF, stallD, stallE, stallM, stallW, flushD, flushE, flushW,
    input  pcSrcE, loadUseD, memBusyM
  );
  // fetch also needs the redirect level to pick the next pc
  modport fetch (
    input stallF, stallD, flushD, pcSrcE
  );
  modport exec (
    input  stallF, stallD, stallE, stallM, stallW, flushD, flushE, flushW,
    output pcSrcE, loadUseD
  );
  modport lsu (
    input  stallM,
    output memBusyM
  );
endinterface

interface dataAccessIf;
  logic                     memReadM;
  logic                     memWriteM;
  logic [hartPkg::xlen-1:0] memAdrM;
  logic [hartPkg::xlen-1:0] writeDataM;
  // load data, lines up with writeback
  logic [hartPkg::xlen-1:0] readDataW;

  modport exec (output memReadM, memWriteM, memAdrM, writeDataM, input readDataW);
  modport lsu  (input memReadM, memWriteM, memAdrM, writeDataM, output readDataW);
endinterface

/* source/hartPkg.sv */
// hart shared definitions

package hartPkg;

  // data and address width
  localparam int xlen = 32;

  //////////////////////////////////////////////////////////////////////
  // major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;

  // funct3 codes for the supported subset
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Word   = 3'b010;
  localparam logic [2:0] f3Beq    = 3'b000;
  localparam logic [2:0] f3Bne    = 3'b001;
  // funct7 that turns ADD into SUB
  localparam logic [6:0] f7Sub    = 7'b0100000;

  // decoded ALU operation
  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluPassB
  } aluOpT;

  //////////////////////////////////////////////////////////////////////
  // instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm11to0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] imm11to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4to0;
    logic [6:0] opcode;
  } sTypeT;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    logic [6:0] opcode;
  } bTypeT;

  typedef struct packed {
    logic [19:0] imm31to12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jTypeT;

  // one word, six views
  typedef union packed {
    rTypeT r;
    iTypeT i;
    sTypeT s;
    bTypeT b;
    uTypeT u;
    jTypeT j;
  } instrT;

  // ADDI x0,x0,0, the bubble word and the decode reset value
  localparam logic [31:0] nopInstr = 32'h0000_0013;

endpackage

/* source/hazardUnit.sv */
// pipeline hazard control

module hazardUnit (
  hazardCtrlIf.hazard hzd
);

  logic fetchHold;

  //////////////////////////////////////////////////////////////////////
  // stalls
  // data wait freezes everything
  assign hzd.stallE = hzd.memBusyM;
  assign hzd.stallM = hzd.memBusyM;
  assign hzd.stallW = hzd.memBusyM;

  // load-use holds only the front end
  assign fetchHold  = hzd.memBusyM || hzd.loadUseD;
  assign hzd.stallF = fetchHold;
  assign hzd.stallD = fetchHold;

  //////////////////////////////////////////////////////////////////////
  // flushes
  // load-use drops the slot that would enter execute
  // taken branch or jump drops the two wrong-path slots
  assign hzd.flushE = !hzd.memBusyM && (hzd.loadUseD || hzd.pcSrcE);
  assign hzd.flushD = !hzd.memBusyM && !hzd.loadUseD && hzd.pcSrcE;

  // writeback bubble if memory holds while writeback moves on
  assign hzd.flushW = hzd.stallM && !hzd.stallW;

endmodule

/* source/intExecUnit.sv */
// integer execution unit
// decode, register file and execute through writeback

module intExecUnit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [hartPkg::xlen-1:0] pcD,
  input  logic [hartPkg::xlen-1:0] instrD,
  output logic [hartPkg::xlen-1:0] pcTargetE,
  hazardCtrlIf.exec                hzd,
  dataAccessIf.exec                mem
);

  // decode stage
  hartPkg::instrT           instD;
  hartPkg::aluOpT           aluOpD;
  logic [4:0]               rs1D, rs2D, rdD;
  logic [hartPkg::xlen-1:0] immD, rd1D, rd2D;
  logic                     regWriteD, isLoadD, isStoreD, isBranchD, isJalD;
  logic                     useImmD, usesRs1D, usesRs2D;
  // execute stage
  hartPkg::aluOpT           aluOpE;
  logic                     validE, regWriteE, isLoadE, isStoreE, isBranchE, isJalE;
  logic                     useImmE, bneE, eqE, takenE;
  logic [4:0]               rs1E, rs2E, rdE;
  logic [hartPkg::xlen-1:0] pcE, immE, rd1E, rd2E;
  logic [hartPkg::xlen-1:0] srcAE, rs2FwdE, srcBE, aluResultE, pcPlus4E;
  // memory stage
  logic                     validM, regWriteM, isLoadM, isStoreM, isJalM;
  logic [4:0]               rdM;
  logic [hartPkg::xlen-1:0] aluResultM, storeDataM, pcPlus4M, resultM;
  // writeback stage
  logic                     validW, regWriteW, isLoadW, isJalW, regWriteEnW;
  logic [4:0]               rdW;
  logic [hartPkg::xlen-1:0] aluResultW, pcPlus4W, resultW;
  logic [hartPkg::xlen-1:0] regFile [32];

  //////////////////////////////////////////////////////////////////////
  // decode
  assign instD = instrD;
  assign rs1D  = instD.r.rs1;
  assign rs2D  = instD.r.rs2;
  assign rdD   = instD.r.rd;

  // control word, anything outside the subset decodes to a bubble
  always_comb begin
    regWriteD = 1'b0;
    isLoadD   = 1'b0;
    isStoreD  = 1'b0;
    isBranchD = 1'b0;
    isJalD    = 1'b0;
    useImmD   = 1'b0;
    usesRs1D  = 1'b0;
    usesRs2D  = 1'b0;
    aluOpD    = hartPkg::aluAdd;
    case (instD.r.opcode)
      hartPkg::opOp: begin
        regWriteD = 1'b1;
        usesRs1D  = 1'b1;
        usesRs2D  = 1'b1;
        case (instD.r.funct3)
          hartPkg::f3AddSub: begin
            aluOpD = (instD.r.funct7 == hartPkg::f7Sub) ? hartPkg::aluSub : hartPkg::aluAdd;
          end
          hartPkg::f3Slt: aluOpD = hartPkg::aluSlt;
          hartPkg::f3Xor: aluOpD = hartPkg::aluXor;
          hartPkg::f3Or:  aluOpD = hartPkg::aluOr;
          hartPkg::f3And: aluOpD = hartPkg::aluAnd;
          default:        regWriteD = 1'b0;
        endcase
      end
      hartPkg::opOpImm: begin
        regWriteD = 1'b1;
        usesRs1D  = 1'b1;
        useImmD   = 1'b1;
        case (instD.i.funct3)
          hartPkg::f3AddSub: aluOpD = hartPkg::aluAdd;
          hartPkg::f3Xor:    aluOpD = hartPkg::aluXor;
          hartPkg::f3Or:     aluOpD = hartPkg::aluOr;
          hartPkg::f3And:    aluOpD = hartPkg::aluAnd;
          default:           regWriteD = 1'b0;
        endcase
      end
      hartPkg::opLui: begin
        regWriteD = 1'b1;
        useImmD   = 1'b1;
        aluOpD    = hartPkg::aluPassB;
      end
      // word accesses only
      hartPkg::opLoad: begin
        regWriteD = (instD.i.funct3 == hartPkg::f3Word);
        isLoadD   = (instD.i.funct3 == hartPkg::f3Word);
        usesRs1D  = 1'b1;
        useImmD   = 1'b1;
      end
      hartPkg::opStore: begin
        isStoreD = (instD.s.funct3 == hartPkg::f3Word);
        usesRs1D = 1'b1;
        usesRs2D = 1'b1;
        useImmD  = 1'b1;
      end
      hartPkg::opBranch: begin
        isBranchD = (instD.b.funct3 == hartPkg::f3Beq) || (instD.b.funct3 == hartPkg::f3Bne);
        usesRs1D  = 1'b1;
        usesRs2D  = 1'b1;
      end
      hartPkg::opJal: begin
        regWriteD = 1'b1;
        isJalD    = 1'b1;
      end
      default: ;
    endcase
  end

  // immediate by format
  always_comb begin
    case (instD.r.opcode)
      hartPkg::opStore:  immD = {{20{instD.s.imm11to5[6]}}, instD.s.imm11to5, instD.s.imm4to0};
      hartPkg::opBranch: immD = {{20{instD.b.imm12}}, instD.b.imm11, instD.b.imm10to5,
                                 instD.b.imm4to1, 1'b0};
      hartPkg::opLui:    immD = {instD.u.imm31to12, 12'd0};
      hartPkg::opJal:    immD = {{12{instD.j.imm20}}, instD.j.imm19to12, instD.j.imm11,
                                 instD.j.imm10to1, 1'b0};
      default:           immD = {{20{instD.i.imm11to0[11]}}, instD.i.imm11to0};
    endcase
  end

  // load result needed right away, hold decode for one cycle
  assign hzd.loadUseD = validE && isLoadE && (rdE != 5'd0) &&
                        ((usesRs1D && rdE == rs1D) || (usesRs2D && rdE == rs2D));

  //////////////////////////////////////////////////////////////////////
  // register file, written in writeback
  assign regWriteEnW = validW && regWriteW && (rdW != 5'd0);

  always_ff @(posedge clk) begin
    if (regWriteEnW) begin
      regFile[rdW] <= resultW;
    end
  end

  // same-cycle write shows through to the read
  assign rd1D = (rs1D == 5'd0) ? '0 : (regWriteEnW && rdW == rs1D) ? resultW : regFile[rs1D];
  assign rd2D = (rs2D == 5'd0) ? '0 : (regWriteEnW && rdW == rs2D) ? resultW : regFile[rs2D];

  //////////////////////////////////////////////////////////////////////
  // decode to execute register
  always_ff @(posedge clk) begin
    if (rst || hzd.flushE) begin
      validE <= 1'b0;
    end else if (!hzd.stallE) begin
      validE <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!hzd.stallE) begin
      regWriteE <= regWriteD;
      isLoadE   <= isLoadD;
      isStoreE  <= isStoreD;
      isBranchE <= isBranchD;
      isJalE    <= isJalD;
      useImmE   <= useImmD;
      bneE      <= (instD.b.funct3 == hartPkg::f3Bne);
      aluOpE    <= aluOpD;
      rs1E      <= rs1D;
      rs2E      <= rs2D;
      rdE       <= rdD;
      pcE       <= pcD;
      immE      <= immD;
      rd1E      <= rd1D;
      rd2E      <= rd2D;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // execute
  // newest producer first: memory stage, then writeback
  assign srcAE = (rs1E != 5'd0 && validM && regWriteM && rdM == rs1E) ? resultM :
                 (rs1E != 5'd0 && validW && regWriteW && rdW == rs1E) ? resultW : rd1E;
  assign rs2FwdE = (rs2E != 5'd0 && validM && regWriteM && rdM == rs2E) ? resultM :
                   (rs2E != 5'd0 && validW && regWriteW && rdW == rs2E) ? resultW : rd2E;
  assign srcBE = useImmE ? immE : rs2FwdE;

  always_comb begin
    case (aluOpE)
      hartPkg::aluSub:   aluResultE = srcAE - srcBE;
      hartPkg::aluAnd:   aluResultE = srcAE & srcBE;
      hartPkg::aluOr:    aluResultE = srcAE | srcBE;
      hartPkg::aluXor:   aluResultE = srcAE ^ srcBE;
      hartPkg::aluSlt:   aluResultE = {31'd0, $signed(srcAE) < $signed(srcBE)};
      hartPkg::aluPassB: aluResultE = srcBE;
      default:           aluResultE = srcAE + srcBE;
    endcase
  end

  // branch compare and redirect
  assign eqE        = (srcAE == rs2FwdE);
  assign takenE     = isBranchE && (bneE ? !eqE : eqE);
  assign hzd.pcSrcE = validE && (isJalE || takenE);
  assign pcTargetE  = pcE + immE;
  // link value for JAL
  assign pcPlus4E   = pcE + 32'd4;

  //////////////////////////////////////////////////////////////////////
  // execute to memory register
  always_ff @(posedge clk) begin
    if (rst) begin
      validM <= 1'b0;
    end else if (!hzd.stallM) begin
      validM <= validE;
    end
  end

  always_ff @(posedge clk) begin
    if (!hzd.stallM) begin
      regWriteM  <= regWriteE;
      isLoadM    <= isLoadE;
      isStoreM   <= isStoreE;
      isJalM     <= isJalE;
      rdM        <= rdE;
      aluResultM <= aluResultE;
      storeDataM <= rs2FwdE;
      pcPlus4M   <= pcPlus4E;
    end
  end

  // request to the lsu, address comes straight from the ALU
  assign mem.memReadM   = validM && isLoadM;
  assign mem.memWriteM  = validM && isStoreM;
  assign mem.memAdrM    = aluResultM;
  assign mem.writeDataM = storeDataM;
  assign resultM        = isJalM ? pcPlus4M : aluResultM;

  //////////////////////////////////////////////////////////////////////
  // memory to writeback register
  always_ff @(posedge clk) begin
    if (rst || hzd.flushW) begin
      validW <= 1'b0;
    end else if (!hzd.stallW) begin
      validW <= validM;
    end
  end

  always_ff @(posedge clk) begin
    if (!hzd.stallW) begin
      regWriteW  <= regWriteM;
      isLoadW    <= isLoadM;
      isJalW     <= isJalM;
      rdW        <= rdM;
      aluResultW <= aluResultM;
      pcPlus4W   <= pcPlus4M;
    end
  end

  // writeback value select
  assign resultW = isLoadW ? mem.readDataW : isJalW ? pcPlus4W : aluResultW;

endmodule

/* source/loadStoreUnit.sv */
// load/store unit
// memory-stage data port with wait states

module loadStoreUnit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [hartPkg::xlen-1:0] memReadData,
  input  logic                     memReady,
  output logic [hartPkg::xlen-1:0] memAdr,
  output logic [hartPkg::xlen-1:0] memWriteData,
  output logic                     memRead,
  output logic                     memWrite,
  hazardCtrlIf.lsu                 hzd,
  dataAccessIf.lsu                 mem
);

  logic reqActiveM;

  //////////////////////////////////////////////////////////////////////
  // external port
  // memory stage holds while waiting, so the request stays steady
  assign memRead      = mem.memReadM;
  assign memWrite     = mem.memWriteM;
  assign memAdr       = mem.memAdrM;
  assign memWriteData = mem.writeDataM;

  assign reqActiveM = mem.memReadM || mem.memWriteM;

  // wait state, freezes the whole pipe
  assign hzd.memBusyM = reqActiveM && !memReady;

  //////////////////////////////////////////////////////////////////////
  // load return
  // capture on the completing edge only
  // value then rides with the load in writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      mem.readDataW <= '0;
    end else if (mem.memReadM && !hzd.stallM) begin
      mem.readDataW <= memReadData;
    end
  end

endmodule

/* source/pipelinedHart.sv */
// five-stage RV32I hart

module pipelinedHart #(
  parameter logic [hartPkg::xlen-1:0] resetVector = '0
) (
  input  logic                     clk,
  input  logic                     rst,
  // instruction port, combinational
  output logic [hartPkg::xlen-1:0] pcF,
  input  logic [hartPkg::xlen-1:0] instrF,
  // data port
  output logic [hartPkg::xlen-1:0] memAdr,
  output logic [hartPkg::xlen-1:0] memWriteData,
  output logic                     memRead,
  output logic                     memWrite,
  input  logic [hartPkg::xlen-1:0] memReadData,
  input  logic                     memReady
);

  // fetch and execute crossings
  logic [hartPkg::xlen-1:0] pcD;
  logic [hartPkg::xlen-1:0] instrD;
  logic [hartPkg::xlen-1:0] pcTargetE;

  // global stall and flush, memory-stage request
  hazardCtrlIf hzdIf ();
  dataAccessIf memIf ();

  //////////////////////////////////////////////////////////////////////
  // units
  // fetch: pc and fetch/decode register
  fetchUnit #(.resetVector(resetVector)) fetch_i (
    .clk       (clk),
    .rst       (rst),
    .instrF    (instrF),
    .pcTargetE (pcTargetE),
    .hzd       (hzdIf.fetch),
    .pcF       (pcF),
    .pcD       (pcD),
    .instrD    (instrD)
  );

  // decode through writeback datapath
  intExecUnit exec_i (
    .clk       (clk),
    .rst       (rst),
    .pcD       (pcD),
    .instrD    (instrD),
    .pcTargetE (pcTargetE),
    .hzd       (hzdIf.exec),
    .mem       (memIf.exec)
  );

  // data port
  loadStoreUnit lsu_i (
    .clk          (clk),
    .rst          (rst),
    .memReadData  (memReadData),
    .memReady     (memReady),
    .memAdr       (memAdr),
    .memWriteData (memWriteData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .hzd          (hzdIf.lsu),
    .mem          (memIf.lsu)
  );

  hazardUnit hazard_i (
    .hzd (hzdIf.hazard)
  );

endmodule

/* tb/clockGen.sv */
// testbench clock and reset

module clockGen #(
  parameter int period      = 20,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic rst
);

  // free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held for a fixed number of cycles, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (resetCycles) @(negedge clk);
    rst <= 1'b0;
  end

endmodule

/* tb/pipelinedHartChecker.sv */
// data port protocol checks

module pipelinedHartChecker (
  input logic                     clk,
  input logic                     rst,
  input logic                     memRead,
  input logic                     memWrite,
  input logic                     memReady,
  input logic [hartPkg::xlen-1:0] memAdr,
  input logic [hartPkg::xlen-1:0] memWriteData
);

  //////////////////////////////////////////////////////////////////////
  // one direction per request
  noBothDirs: assert property (@(posedge clk) disable iff (rst)
    !(memRead && memWrite))
    else $error("memRead and memWrite high in the same cycle");

  // word accesses only
  alignedAdr: assert property (@(posedge clk) disable iff (rst)
    (memRead || memWrite) |-> memAdr[1:0] == 2'b00)
    else $error("data port address not word aligned");

  // a waiting request keeps address, data and direction
  heldRequest: assert property (@(posedge clk) disable iff (rst)
    (memRead || memWrite) && !memReady |=>
      memRead == $past(memRead) && memWrite == $past(memWrite) &&
      memAdr == $past(memAdr) && (!memWrite || memWriteData == $past(memWriteData)))
    else $error("data port request changed while waiting for memReady");

endmodule

/* tb/pipelinedHartTb.sv */
// pipelined hart testbench

module pipelinedHartTb;

  // one program row and the store it may produce
  typedef struct packed {
    logic [31:0] instr;
    logic        hasStore;
    logic [31:0] adr;
    logic [31:0] data;
  } rowT;

  localparam logic [31:0] endAdr = 32'h0000_0100;

  logic        clk, rst;
  logic [31:0] pcF, instrF, memAdr, memWriteData;
  logic        memRead, memWrite;
  logic [31:0] memReadData = 32'h0;
  logic        memReady = 1'b0;

  logic [31:0] imem [64];
  logic [31:0] dmem [128];
  rowT         progRows[$];
  logic [31:0] expAdr[$];
  logic [31:0] expData[$];
  int          nextStore = 0;
  int          cycles = 0;
  int          cycleLimit = 0;
  // wait-state generator
  bit          pending = 1'b0;
  int          waitLeft = 0;

  clockGen #(.period(20), .resetCycles(10)) clock_i (.clk(clk), .rst(rst));

  pipelinedHart #(.resetVector(32'h0)) dut_i (
    .clk          (clk),
    .rst          (rst),
    .pcF          (pcF),
    .instrF       (instrF),
    .memAdr       (memAdr),
    .memWriteData (memWriteData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memReadData  (memReadData),
    .memReady     (memReady)
  );

  bind pipelinedHart pipelinedHartChecker checker_i (
    .clk          (clk),
    .rst          (rst),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memReady     (memReady),
    .memAdr       (memAdr),
    .memWriteData (memWriteData)
  );

  //////////////////////////////////////////////////////////////////////
  // reporting
  task failAndStop;
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      failAndStop();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction assembly through the format views
  function automatic logic [31:0] rTypeWord(logic [2:0] f3, logic [6:0] f7,
                                            int rd, int rs1, int rs2);
    hartPkg::instrT w;
    w.r.opcode = hartPkg::opOp;
    w.r.funct3 = f3;
    w.r.funct7 = f7;
    w.r.rd     = 5'(rd);
    w.r.rs1    = 5'(rs1);
    w.r.rs2    = 5'(rs2);
    return w;
  endfunction

  // I format for OP-IMM and LW alike
  function automatic logic [31:0] iTypeWord(logic [6:0] op, logic [2:0] f3,
                                            int rd, int rs1, int imm);
    hartPkg::instrT w;
    w.i.opcode   = op;
    w.i.funct3   = f3;
    w.i.rd       = 5'(rd);
    w.i.rs1      = 5'(rs1);
    w.i.imm11to0 = 12'(imm);
    return w;
  endfunction

  // SW rs2, imm(rs1)
  function automatic logic [31:0] sTypeWord(int rs2, int rs1, int imm);
    hartPkg::instrT w;
    logic [11:0]    im;
    im           = 12'(imm);
    w.s.opcode   = hartPkg::opStore;
    w.s.funct3   = hartPkg::f3Word;
    w.s.rs1      = 5'(rs1);
    w.s.rs2      = 5'(rs2);
    w.s.imm11to5 = im[11:5];
    w.s.imm4to0  = im[4:0];
    return w;
  endfunction

  function automatic logic [31:0] bTypeWord(logic [2:0] f3, int rs1, int rs2, int offset);
    hartPkg::instrT w;
    logic [12:0]    im;
    im           = 13'(offset);
    w.b.opcode   = hartPkg::opBranch;
    w.b.funct3   = f3;
    w.b.rs1      = 5'(rs1);
    w.b.rs2      = 5'(rs2);
    w.b.imm12    = im[12];
    w.b.imm11    = im[11];
    w.b.imm10to5 = im[10:5];
    w.b.imm4to1  = im[4:1];
    return w;
  endfunction

  function automatic logic [31:0] luiWord(int rd, int upper);
    hartPkg::instrT w;
    w.u.opcode    = hartPkg::opLui;
    w.u.rd        = 5'(rd);
    w.u.imm31to12 = 20'(upper);
    return w;
  endfunction

  function automatic logic [31:0] jalWord(int rd, int offset);
    hartPkg::instrT w;
    logic [20:0]    im;
    im            = 21'(offset);
    w.j.opcode    = hartPkg::opJal;
    w.j.rd        = 5'(rd);
    w.j.imm20     = im[20];
    w.j.imm19to12 = im[19:12];
    w.j.imm11     = im[11];
    w.j.imm10to1  = im[10:1];
    return w;
  endfunction

  task automatic addRow(input logic [31:0] instr, input logic hasStore = 1'b0,
                        input logic [31:0] adr = 32'h0, input logic [31:0] data = 32'h0);
    progRows.push_back({instr, hasStore, adr, data});
  endtask

  //////////////////////////////////////////////////////////////////////
  // program and the stores it must produce
  initial begin
    void'($urandom(30));
    // arithmetic with x2 = -3 and forwarding at distance 1 and 2
    addRow(iTypeWord(hartPkg::opOpImm, hartPkg::f3AddSub, 1, 0, 5));
    addRow(iTypeWord(hartPkg::opOpImm, hartPkg::f3AddSub, 2, 0, -3));
    addRow(rTypeWord(hartPkg::f3AddSub, 7'd0, 3, 1, 2));
    addRow(sTypeWord(3, 0, 'h00), 1'b1, 32'h00, 32'h0000_0002);
    // sub and signed slt with stores at distance 3
    addRow(rTypeWord(hartPkg::f3AddSub, hartPkg::f7Sub, 4, 1, 2));
    addRow(rTypeWord(hartPkg::f3Slt, 7'd0, 5, 2, 1));
    addRow(rTypeWord(hartPkg::f3Slt, 7'd0, 6, 1, 2));
    addRow(sTypeWord(4, 0, 'h04), 1'b1, 32'h04, 32'h0000_0008);
    addRow(sTypeWord(5, 0, 'h08), 1'b1, 32'h08, 32'h0000_0001);
    addRow(sTypeWord(6, 0, 'h0c), 1'b1, 32'h0c, 32'h0000_0000);
    // lui and logic ops
    addRow(luiWord(7, 'h12345));
    addRow(iTypeWord(hartPkg::opOpImm, hartPkg::f3Or, 7, 7, 'h678));
    addRow(iTypeWord(hartPkg::opOpImm, hartPkg::f3And, 8, 7, 'h0f0));
    addRow(iTypeWord(hartPkg::opOpImm, hartPkg::f3Xor, 9, 7, -1));
    addRow(rTypeWord(hartPkg::f3Or, 7'd0, 10, 7, 9));
    addRow(rTypeWord(hartPkg::f3Xor, 7'd0, 11, 7, 8));
    addRow(rTypeWord(hartPkg::f3And, 7'd0, 12, 9, 10));
    addRow(sTypeWord(7, 0, 'h10), 1'b1, 32'h10, 32'h1234_5678);
    addRow(sTypeWord(8, 0, 'h14), 1'b1, 32'h14, 32'h0000_0070);
    addRow(sTypeWord(10, 0, 'h18), 1'b1, 32'h18, 32'hffff_ffff);
    addRow(sTypeWord(11, 0, 'h1c), 1'b1, 32'h1c, 32'h1234_5608);
    addRow(sTypeWord(12, 0, 'h20), 1'b1, 32'h20, 32'hedcb_a987);
    // x0 stays zero
    addRow(iTypeWord(hartPkg::opOpImm, hartPkg::f3AddSub, 0, 0, 99));
    addRow(sTypeWord(0, 0, 'h24), 1'b1, 32'h24, 32'h0000_0000);
    // store then load back with a dependent use right after each load
    addRow(sTypeWord(7, 0, 'h28), 1'b1, 32'h28, 32'h1234_5678);
    addRow(iTypeWord(hartPkg::opLoad, hartPkg::f3Word, 13, 0, 'h28));
    addRow(iTypeWord(hartPkg::opOpImm, hartPkg::f3AddSub, 14, 13, 1));
    addRow(sTypeWord(14, 0, 'h2c), 1'b1, 32'h2c, 32'h1234_5679);
    addRow(iTypeWord(hartPkg::opLoad, hartPkg::f3Word, 15, 0, 'h00));
    addRow(sTypeWord(15, 0, 'h30), 1'b1, 32'h30, 32'h0000_0002);
    // taken beq skips two stores
    addRow(bTypeWord(hartPkg::f3Beq, 1, 1, 12));
    addRow(sTypeWord(1, 0, 'h80));
    addRow(sTypeWord(1, 0, 'h84));
    // bne not taken falls through
    addRow(bTypeWord(hartPkg::f3Bne, 1, 1, 12));
    addRow(sTypeWord(1, 0, 'h34), 1'b1, 32'h34, 32'h0000_0005);
    // jal at 0x8c links 0x90
    addRow(jalWord(16, 12));
    addRow(sTypeWord(2, 0, 'h88));
    addRow(sTypeWord(2, 0, 'h8c));
    addRow(sTypeWord(16, 0, 'h38), 1'b1, 32'h38, 32'h0000_0090);
    // end marker
    addRow(sTypeWord(0, 0, 'h100));

    // rows into instruction memory and the expected store list
    foreach (imem[i]) imem[i] = hartPkg::nopInstr;
    for (int i = 0; i < progRows.size(); i++) begin
      imem[i] = progRows[i].instr;
      if (progRows[i].hasStore) begin
        expAdr.push_back(progRows[i].adr);
        expData.push_back(progRows[i].data);
      end
    end
    cycleLimit = 10 * progRows.size() + 50;

    // reset state up to the release edge
    @(negedge clk);
    while (rst) begin
      checkEq("pcF", pcF, 32'h0);
      checkEq("memRead", 32'(memRead), 32'h0);
      checkEq("memWrite", 32'(memWrite), 32'h0);
      @(negedge clk);
    end
    checkEq("memRead", 32'(memRead), 32'h0);
    checkEq("memWrite", 32'(memWrite), 32'h0);
  end

  //////////////////////////////////////////////////////////////////////
  // combinational instruction memory
  assign instrF = imem[pcF[7:2]];

  // data memory response with 0 to 3 wait cycles per request
  always @(negedge clk) begin
    if (!rst && (memRead || memWrite)) begin
      if (!pending) begin
        waitLeft = $urandom % 4;
        pending  = 1'b1;
      end
      if (waitLeft == 0) begin
        memReady    <= 1'b1;
        memReadData <= dmem[memAdr[8:2]];
        pending     = 1'b0;
      end else begin
        memReady <= 1'b0;
        waitLeft = waitLeft - 1;
      end
    end else begin
      memReady <= 1'b0;
      pending  = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // store completion with memory write and order check
  always @(posedge clk) begin
    if (rst) begin
      // fill depends on the byte address
      foreach (dmem[i]) dmem[i] <= 32'hdead_0000 ^ 32'(i * 4);
    end else if (memWrite && memReady) begin
      dmem[memAdr[8:2]] <= memWriteData;
      if (memAdr == endAdr) begin
        if (nextStore == expAdr.size()) begin
          $display("PASS: all tests");
          $finish;
        end else begin
          $display("end store reached with %0d expected stores missing, next at 0x%08h",
                   expAdr.size() - nextStore, expAdr[nextStore]);
          failAndStop();
        end
      end else if (nextStore == expAdr.size()) begin
        $display("store to 0x%08h at %0t is not in the expected list", memAdr, $time);
        failAndStop();
      end else begin
        checkEq("memAdr", memAdr, expAdr[nextStore]);
        checkEq("memWriteData", memWriteData, expData[nextStore]);
        nextStore = nextStore + 1;
      end
    end
  end

  // timeout at 10 cycles per row plus 50
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("timeout, end store not seen within %0d cycles", cycleLimit);
      failAndStop();
    end
  end

endmodule
